// ==== all.f ====
hw/noc_pkg.sv
hw/input_vc_buffer.sv
hw/switch_allocator.sv
hw/output_port.sv
hw/router_core.sv
hw/router_wrap.sv
dv/router_assert.sv
dv/router_tb.sv

// ==== dv/router_tb.sv ====
`timescale 1ns/1ps

module router_tb;

  localparam int BUF_DEPTH = 4;
  localparam int NUM_PORTS = noc_pkg::NUM_PORTS;
  localparam int NUM_VC    = noc_pkg::NUM_VC;
  localparam int NPKT      = 12;
  localparam int MAX_CYC   = 20000;
  localparam logic [1:0] MY_X = 2'd1;
  localparam logic [1:0] MY_Y = 2'd1;

  logic               clk;
  logic               rst_n;
  logic [1:0]         my_xpos;
  logic [1:0]         my_ypos;
  noc_pkg::link_in_t  in_link  [NUM_PORTS];
  noc_pkg::link_ctl_t in_ctl   [NUM_PORTS];
  noc_pkg::link_in_t  out_link [NUM_PORTS];
  noc_pkg::link_ctl_t out_ctl  [NUM_PORTS];

  logic [31:0] rng_state;
  int          errors;
  int          cycle;
  int          total_rcvd;
  logic        done;

  // Sources
  int         src_pkt    [NUM_PORTS];
  int         src_flit   [NUM_PORTS];
  int         src_credit [NUM_PORTS][NUM_VC];
  int         flits_sent [NUM_PORTS][NUM_VC];
  int         acks_seen  [NUM_PORTS][NUM_VC];
  logic [1:0] exp_lck    [NUM_PORTS];

  // Model, one entry per packet, indexed by source and sequence number
  int             pkt_len  [NUM_PORTS][NPKT];
  int             pkt_vch  [NUM_PORTS][NPKT];
  logic [1:0]     pkt_dx   [NUM_PORTS][NPKT];
  logic [1:0]     pkt_dy   [NUM_PORTS][NPKT];
  noc_pkg::port_e pkt_port [NUM_PORTS][NPKT];
  int             pkt_rcvd [NUM_PORTS][NPKT];

  // Sinks and their scoreboards
  int          asm_busy  [NUM_PORTS][NUM_VC];
  int          asm_src   [NUM_PORTS][NUM_VC];
  int          asm_seq   [NUM_PORTS][NUM_VC];
  int          asm_idx   [NUM_PORTS][NUM_VC];
  logic [15:0] ack_sched [NUM_PORTS][NUM_VC];
  logic [1:0]  pkt_lck   [NUM_PORTS];
  logic [1:0]  hold      [NUM_PORTS];
  int          hold_left [NUM_PORTS];
  int          hold_at   [NUM_PORTS];
  int          hold_vch  [NUM_PORTS];
  int          hold_done [NUM_PORTS];

  router_wrap #(
    .BUF_DEPTH(BUF_DEPTH)
  ) router_wrap_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_link  (in_link),
    .in_ctl   (in_ctl),
    .out_link (out_link),
    .out_ctl  (out_ctl),
    .my_xpos  (my_xpos),
    .my_ypos  (my_ypos)
  );

  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return int'(rng_state[30:16]) % n;
  endfunction

  // X first, then Y, relative to (1,1)
  function automatic noc_pkg::port_e expected_port(input logic [1:0] dx, input logic [1:0] dy);
    int step_x;
    int step_y;
    step_x = int'(dx) - int'(MY_X);
    step_y = int'(dy) - int'(MY_Y);
    if (step_x != 0) return (step_x > 0) ? noc_pkg::PORT_EAST : noc_pkg::PORT_WEST;
    if (step_y != 0) return (step_y > 0) ? noc_pkg::PORT_NORTH : noc_pkg::PORT_SOUTH;
    return noc_pkg::PORT_LOCAL;
  endfunction

  function automatic noc_pkg::flit_type_e kind_for(input int len, input int idx);
    if (len == 1) return noc_pkg::FLIT_SINGLE;
    if (idx == 0) return noc_pkg::FLIT_HEAD;
    if (idx == len - 1) return noc_pkg::FLIT_TAIL;
    return noc_pkg::FLIT_BODY;
  endfunction

  // Head user data starts with the source port and sequence number
  function automatic logic [32:0] head_payload(input int s, input int q);
    return {pkt_dx[s][q], pkt_dy[s][q], 3'(s), 8'(q), 18'(s * 4099 + q * 31)};
  endfunction

  function automatic logic [32:0] body_payload(input int s, input int q, input int idx);
    int tag;
    tag = s * 256 + q;
    return {11'(tag), 20'(tag * 1021 + idx * 77), 2'(idx)};
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic new_packet(input int p);
    int q;
    q = src_pkt[p];
    pkt_len[p][q]  = 1 + rand_below(4);
    pkt_vch[p][q]  = rand_below(2);
    pkt_dx[p][q]   = 2'(rand_below(4));
    pkt_dy[p][q]   = 2'(rand_below(4));
    pkt_port[p][q] = expected_port(pkt_dx[p][q], pkt_dy[p][q]);
  endtask

  task automatic run_source(input int p);
    int q;
    int v;
    int idx;
    noc_pkg::flit_t f;
    for (int c = 0; c < NUM_VC; c++) begin
      if (in_ctl[p].ack[c]) begin
        src_credit[p][c]++;
        acks_seen[p][c]++;
        if (src_credit[p][c] > BUF_DEPTH) begin
          report_error($sformatf("source %0d channel %0d got back more credits than sent", p, c));
        end
      end
      // Ready means room for two more flits in the router's buffer
      check_eq($sformatf("in_ctl[%0d].rdy[%0d]", p, c), in_ctl[p].rdy[c],
               src_credit[p][c] >= 2);
    end
    check_eq($sformatf("in_ctl[%0d].lck", p), in_ctl[p].lck, exp_lck[p]);
    in_link[p].valid = 1'b0;
    if (src_pkt[p] >= NPKT || rand_below(4) == 0) return;
    q   = src_pkt[p];
    v   = pkt_vch[p][q];
    idx = src_flit[p];
    if (src_credit[p][v] == 0) return;
    f.kind    = kind_for(pkt_len[p][q], idx);
    f.payload = (idx == 0) ? head_payload(p, q) : body_payload(p, q, idx);
    in_link[p].flit  = f;
    in_link[p].valid = 1'b1;
    in_link[p].vch   = 1'(v);
    src_credit[p][v]--;
    flits_sent[p][v]++;
    if (f.kind == noc_pkg::FLIT_HEAD) exp_lck[p][v] = 1'b1;
    if (f.kind == noc_pkg::FLIT_TAIL) exp_lck[p][v] = 1'b0;
    if (idx == pkt_len[p][q] - 1) begin
      src_flit[p] = 0;
      src_pkt[p]++;
      if (src_pkt[p] < NPKT) new_packet(p);
    end else begin
      src_flit[p]++;
    end
  endtask

  task automatic close_packet(input int s, input int q);
    check_eq($sformatf("pkt_rcvd[%0d][%0d]", s, q), pkt_rcvd[s][q], 0);
    pkt_rcvd[s][q]++;
    total_rcvd++;
  endtask

  task automatic run_sink(input int o);
    int v;
    int s;
    int q;
    int slot;
    noc_pkg::flit_t f;
    noc_pkg::head_payload_t h;
    if (out_link[o].valid) begin
      v = int'(out_link[o].vch);
      f = out_link[o].flit;
      h = f.payload;
      if (f.kind inside {noc_pkg::FLIT_HEAD, noc_pkg::FLIT_SINGLE}) begin
        // Router saw last cycle's lck when it granted this head
        check_eq($sformatf("out_ctl[%0d].lck[%0d] at head", o, v), hold[o][v], 1'b0);
        check_eq($sformatf("open packet on out %0d vch %0d", o, v), asm_busy[o][v], 0);
        s = int'(h.data[28:26]);
        q = int'(h.data[25:18]);
        if (s >= NUM_PORTS || q >= NPKT) begin
          report_error($sformatf("head on output %0d carries an unknown tag", o));
        end else begin
          check_eq($sformatf("out_link[%0d] head payload", o), f.payload, head_payload(s, q));
          check_eq($sformatf("port of pkt %0d.%0d", s, q), o, pkt_port[s][q]);
          check_eq($sformatf("vch of pkt %0d.%0d", s, q), v, pkt_vch[s][q]);
          check_eq($sformatf("out_link[%0d] kind", o), f.kind, kind_for(pkt_len[s][q], 0));
          if (f.kind == noc_pkg::FLIT_SINGLE) begin
            close_packet(s, q);
          end else begin
            asm_busy[o][v] = 1;
            asm_src[o][v]  = s;
            asm_seq[o][v]  = q;
            asm_idx[o][v]  = 1;
            pkt_lck[o][v]  = 1'b1;
          end
        end
      end else if (asm_busy[o][v] == 0) begin
        report_error($sformatf("body or tail flit with no open packet on output %0d", o));
      end else begin
        s = asm_src[o][v];
        q = asm_seq[o][v];
        check_eq($sformatf("out_link[%0d] body payload", o), f.payload,
                 body_payload(s, q, asm_idx[o][v]));
        check_eq($sformatf("out_link[%0d] kind", o), f.kind,
                 kind_for(pkt_len[s][q], asm_idx[o][v]));
        if (f.kind == noc_pkg::FLIT_TAIL) begin
          close_packet(s, q);
          asm_busy[o][v] = 0;
          pkt_lck[o][v]  = 1'b0;
        end else begin
          asm_idx[o][v]++;
        end
      end
      // Credit return after 0 to 3 cycles, at most one pulse per cycle
      slot = rand_below(4);
      while (slot < 15 && ack_sched[o][v][slot]) slot++;
      ack_sched[o][v][slot] = 1'b1;
    end
    // One lck pulse on a channel the sink sees as idle
    if (hold_done[o] == 0 && cycle >= hold_at[o] && !pkt_lck[o][hold_vch[o]]) begin
      hold_left[o] = 6;
      hold_done[o] = 1;
    end
    hold[o] = '0;
    if (hold_left[o] > 0) begin
      hold[o][hold_vch[o]] = 1'b1;
      hold_left[o]--;
    end
    for (int c = 0; c < NUM_VC; c++) begin
      out_ctl[o].ack[c] = ack_sched[o][c][0];
      ack_sched[o][c]   = ack_sched[o][c] >> 1;
    end
    out_ctl[o].lck = pkt_lck[o] | hold[o];
    out_ctl[o].rdy = 2'b11;
  endtask

  function automatic logic all_finished();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (src_pkt[p] < NPKT) return 1'b0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (ack_sched[p][v] != '0 || src_credit[p][v] != BUF_DEPTH) return 1'b0;
      end
    end
    return total_rcvd == NUM_PORTS * NPKT;
  endfunction

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    my_xpos    = MY_X;
    my_ypos    = MY_Y;
    rng_state  = 32'd63;
    errors     = 0;
    cycle      = 0;
    total_rcvd = 0;
    done       = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      in_link[p]   = '0;
      out_ctl[p]   = '0;
      src_pkt[p]   = 0;
      src_flit[p]  = 0;
      exp_lck[p]   = '0;
      pkt_lck[p]   = '0;
      hold[p]      = '0;
      hold_left[p] = 0;
      hold_done[p] = 0;
      hold_at[p]   = 10 + rand_below(80);
      hold_vch[p]  = rand_below(2);
      for (int v = 0; v < NUM_VC; v++) begin
        src_credit[p][v] = BUF_DEPTH;
        flits_sent[p][v] = 0;
        acks_seen[p][v]  = 0;
        asm_busy[p][v]   = 0;
        ack_sched[p][v]  = '0;
      end
      for (int q = 0; q < NPKT; q++) begin
        pkt_rcvd[p][q] = 0;
      end
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_eq($sformatf("out_link[%0d].valid", p), out_link[p].valid, 1'b0);
      check_eq($sformatf("in_ctl[%0d].ack", p), in_ctl[p].ack, 2'b00);
      check_eq($sformatf("in_ctl[%0d].lck", p), in_ctl[p].lck, 2'b00);
      check_eq($sformatf("in_ctl[%0d].rdy", p), in_ctl[p].rdy, 2'b11);
      new_packet(p);
    end
    while (!done && cycle < MAX_CYC) begin
      @(posedge clk);
      #2;
      cycle++;
      for (int p = 0; p < NUM_PORTS; p++) run_source(p);
      for (int o = 0; o < NUM_PORTS; o++) run_sink(o);
      done = all_finished();
    end
    if (!done) begin
      report_error($sformatf("timeout after %0d cycles with %0d packets received",
                             cycle, total_rcvd));
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int v = 0; v < NUM_VC; v++) begin
        check_eq($sformatf("acks on in %0d vch %0d", p, v), acks_seen[p][v], flits_sent[p][v]);
        check_eq($sformatf("credit of in %0d vch %0d", p, v), src_credit[p][v], BUF_DEPTH);
        check_eq($sformatf("open packet on out %0d vch %0d", p, v), asm_busy[p][v], 0);
      end
      for (int q = 0; q < NPKT; q++) begin
        check_eq($sformatf("pkt_rcvd[%0d][%0d]", p, q), pkt_rcvd[p][q], 1);
      end
    end
    $display("cycles %0d, packets %0d of %0d, errors %0d",
             cycle, total_rcvd, NUM_PORTS * NPKT, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== dv/router_assert.sv ====
`timescale 1ns/1ps

module router_assert #(
  parameter int BUF_DEPTH = 4
) (
  input logic                          clk,
  input logic                          rst_n,
  input logic [noc_pkg::NUM_VC-1:0]    deq       [noc_pkg::NUM_PORTS],
  input noc_pkg::port_e                req_port  [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC],
  input logic [noc_pkg::NUM_PORTS-1:0] send,
  input logic [noc_pkg::NUM_PORTS-1:0] send_vch,
  input logic [noc_pkg::NUM_VC-1:0]    credit_ok [noc_pkg::NUM_PORTS],
  input logic [noc_pkg::NUM_VC-1:0]    down_ack  [noc_pkg::NUM_PORTS],
  input noc_pkg::link_in_t             out_link  [noc_pkg::NUM_PORTS]
);

  // Dequeues that land on each output this cycle
  int grants [noc_pkg::NUM_PORTS];
  // Credits rebuilt from sends and returns
  int credit [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC];

  always_comb begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      grants[o] = 0;
    end
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        if (deq[i][v]) begin
          grants[req_port[i][v]] = grants[req_port[i][v]] + 1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
          credit[o][v] <= BUF_DEPTH;
        end
      end
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
          credit[o][v] <= credit[o][v] - int'(send[o] && send_vch[o] == 1'(v))
                          + int'(down_ack[o][v]);
        end
      end
    end
  end

  for (genvar o = 0; o < noc_pkg::NUM_PORTS; o++) begin : g_port
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n) grants[o] <= 1)
      else $error("output %0d granted to more than one input", o);
    for (genvar v = 0; v < noc_pkg::NUM_VC; v++) begin : g_vc
      a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        (send[o] && send_vch[o] == 1'(v)) |-> credit[o][v] > 0)
        else $error("output %0d channel %0d sent with no credit left", o, v);
      a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (down_ack[o][v] && !(send[o] && send_vch[o] == 1'(v))) |-> credit[o][v] < BUF_DEPTH)
        else $error("output %0d channel %0d credit above buffer depth", o, v);
      a_credit_ok: assert property (@(posedge clk) disable iff (!rst_n)
        credit_ok[o][v] == (credit[o][v] != 0))
        else $error("output %0d channel %0d credit_ok disagrees with count", o, v);
      a_valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
        (out_link[o].valid && out_link[o].vch == 1'(v)) |-> $past(credit[o][v] > 0))
        else $error("output %0d channel %0d flit left on zero credit", o, v);
    end
  end

endmodule

bind router_core router_assert #(
  .BUF_DEPTH(BUF_DEPTH)
) router_assert_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .deq       (deq),
  .req_port  (req_port),
  .send      (send),
  .send_vch  (send_vch),
  .credit_ok (credit_ok),
  .down_ack  (down_ack),
  .out_link  (out_link)
);

// ==== hw/router_wrap.sv ====
`timescale 1ns/1ps

module router_wrap #(
  parameter int BUF_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  // Links from the neighbours and their credit returns
  input  noc_pkg::link_in_t  in_link  [noc_pkg::NUM_PORTS],
  output noc_pkg::link_ctl_t in_ctl   [noc_pkg::NUM_PORTS],
  // Links towards the neighbours
  output noc_pkg::link_in_t  out_link [noc_pkg::NUM_PORTS],
  input  noc_pkg::link_ctl_t out_ctl  [noc_pkg::NUM_PORTS],
  // Router position in the mesh
  input  logic [1:0]         my_xpos,
  input  logic [1:0]         my_ypos
);

  router_core #(
    .BUF_DEPTH(BUF_DEPTH)
  ) u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_link  (in_link),
    .in_ctl   (in_ctl),
    .out_link (out_link),
    .out_ctl  (out_ctl),
    .my_xpos  (my_xpos),
    .my_ypos  (my_ypos)
  );

endmodule

// ==== hw/router_core.sv ====
`timescale 1ns/1ps

module router_core #(
  parameter int BUF_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  noc_pkg::link_in_t  in_link  [noc_pkg::NUM_PORTS],
  output noc_pkg::link_ctl_t in_ctl   [noc_pkg::NUM_PORTS],
  output noc_pkg::link_in_t  out_link [noc_pkg::NUM_PORTS],
  input  noc_pkg::link_ctl_t out_ctl  [noc_pkg::NUM_PORTS],
  input  logic [1:0]         my_xpos,
  input  logic [1:0]         my_ypos
);

  // Head-of-line view of every input channel
  noc_pkg::flit_t                head_flit [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC];
  logic [noc_pkg::NUM_VC-1:0]    req_valid [noc_pkg::NUM_PORTS];
  noc_pkg::port_e                req_port  [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC];
  noc_pkg::flit_type_e           req_kind  [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC];
  logic [noc_pkg::NUM_VC-1:0]    deq       [noc_pkg::NUM_PORTS];

  // Per output port
  logic [noc_pkg::NUM_VC-1:0]    credit_ok [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_VC-1:0]    down_ack  [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_VC-1:0]    down_lck  [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] send;
  noc_pkg::port_e                send_in   [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] send_vch;
  noc_pkg::flit_t                xbar_flit [noc_pkg::NUM_PORTS];

  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_in
    input_vc_buffer #(
      .BUF_DEPTH(BUF_DEPTH)
    ) u_in (
      .clk       (clk),
      .rst_n     (rst_n),
      .my_xpos   (my_xpos),
      .my_ypos   (my_ypos),
      .in_link   (in_link[p]),
      .in_ctl    (in_ctl[p]),
      .deq       (deq[p]),
      .head_flit (head_flit[p]),
      .req_valid (req_valid[p]),
      .req_port  (req_port[p])
    );
  end

  switch_allocator u_alloc (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_port  (req_port),
    .req_kind  (req_kind),
    .credit_ok (credit_ok),
    .down_lck  (down_lck),
    .deq       (deq),
    .send      (send),
    .send_in   (send_in),
    .send_vch  (send_vch)
  );

  always_comb begin
    for (int p = 0; p < noc_pkg::NUM_PORTS; p++) begin
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        req_kind[p][v] = head_flit[p][v].kind;
      end
      down_ack[p] = out_ctl[p].ack;
      down_lck[p] = out_ctl[p].lck;
      // Crossbar, granted input and channel onto this output
      xbar_flit[p] = head_flit[send_in[p]][send_vch[p]];
    end
  end

  for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_out
    output_port #(
      .BUF_DEPTH(BUF_DEPTH)
    ) u_out (
      .clk       (clk),
      .rst_n     (rst_n),
      .send      (send[p]),
      .send_vch  (send_vch[p]),
      .flit      (xbar_flit[p]),
      .ack       (down_ack[p]),
      .credit_ok (credit_ok[p]),
      .out_link  (out_link[p])
    );
  end

endmodule

// ==== hw/output_port.sv ====
`timescale 1ns/1ps

module output_port #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       send,
  input  logic                       send_vch,
  input  noc_pkg::flit_t             flit,
  input  logic [noc_pkg::NUM_VC-1:0] ack,
  output logic [noc_pkg::NUM_VC-1:0] credit_ok,
  output noc_pkg::link_in_t          out_link
);

  localparam int CRD_W = $clog2(BUF_DEPTH + 1);

  // Free entries left in the downstream buffer, per channel
  logic [CRD_W-1:0] credit [noc_pkg::NUM_VC];
  noc_pkg::flit_t   flit_q;
  logic             valid_q;
  logic             vch_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        credit[v] <= CRD_W'(BUF_DEPTH);
      end
      valid_q <= 1'b0;
      vch_q   <= 1'b0;
    end else begin
      valid_q <= send;
      if (send) begin
        vch_q <= send_vch;
      end
      // Spend and return in the same cycle cancel out
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        case ({send && (send_vch == 1'(v)), ack[v]})
          2'b10:   credit[v] <= credit[v] - 1'b1;
          2'b01:   credit[v] <= credit[v] + 1'b1;
          default: credit[v] <= credit[v];
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      flit_q <= flit;
    end
  end

  always_comb begin
    for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
      credit_ok[v] = (credit[v] != '0);
    end
  end

  assign out_link = '{flit: flit_q, valid: valid_q, vch: vch_q};

endmodule

// ==== hw/switch_allocator.sv ====
`timescale 1ns/1ps

module switch_allocator (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [noc_pkg::NUM_VC-1:0]    req_valid [noc_pkg::NUM_PORTS],
  input  noc_pkg::port_e                req_port  [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC],
  input  noc_pkg::flit_type_e           req_kind  [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC],
  input  logic [noc_pkg::NUM_VC-1:0]    credit_ok [noc_pkg::NUM_PORTS],
  input  logic [noc_pkg::NUM_VC-1:0]    down_lck  [noc_pkg::NUM_PORTS],
  output logic [noc_pkg::NUM_VC-1:0]    deq       [noc_pkg::NUM_PORTS],
  output logic [noc_pkg::NUM_PORTS-1:0] send,
  output noc_pkg::port_e                send_in   [noc_pkg::NUM_PORTS],
  output logic [noc_pkg::NUM_PORTS-1:0] send_vch
);

  // Output channel ownership, by output port then channel
  logic [noc_pkg::NUM_VC-1:0]    owned [noc_pkg::NUM_PORTS];
  noc_pkg::port_e                owner [noc_pkg::NUM_PORTS][noc_pkg::NUM_VC];

  logic [noc_pkg::NUM_VC-1:0]    elig [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] in_req;
  logic [noc_pkg::NUM_PORTS-1:0] in_vch;
  noc_pkg::port_e                in_port [noc_pkg::NUM_PORTS];

  // Round-robin pointers for both stages
  logic [noc_pkg::NUM_PORTS-1:0] in_rr;
  logic [2:0]                    out_rr [noc_pkg::NUM_PORTS];

  always_comb begin
    noc_pkg::port_e o;
    logic           is_head;
    logic           own_hit;
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        o          = req_port[i][v];
        is_head    = req_kind[i][v] inside {noc_pkg::FLIT_HEAD, noc_pkg::FLIT_SINGLE};
        own_hit    = owned[o][v] && (owner[o][v] == noc_pkg::port_e'(i));
        // New packets need a free channel the neighbour is not holding
        elig[i][v] = req_valid[i][v] && credit_ok[o][v] &&
                     (own_hit || (is_head && !owned[o][v] && !down_lck[o][v]));
      end
    end
  end

  // Stage one, one channel per input
  always_comb begin
    logic vs;
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      in_req[i]  = 1'b0;
      in_vch[i]  = 1'b0;
      in_port[i] = noc_pkg::PORT_LOCAL;
      for (int k = 0; k < noc_pkg::NUM_VC; k++) begin
        vs = in_rr[i] ^ 1'(k);
        if (!in_req[i] && elig[i][vs]) begin
          in_req[i]  = 1'b1;
          in_vch[i]  = vs;
          in_port[i] = req_port[i][vs];
        end
      end
    end
  end

  // Stage two, one input per output
  always_comb begin
    int idx;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      send[o]     = 1'b0;
      send_in[o]  = noc_pkg::PORT_LOCAL;
      send_vch[o] = 1'b0;
      for (int k = 0; k < noc_pkg::NUM_PORTS; k++) begin
        idx = (int'(out_rr[o]) + k) % noc_pkg::NUM_PORTS;
        if (!send[o] && in_req[idx] && (in_port[idx] == noc_pkg::port_e'(o))) begin
          send[o]     = 1'b1;
          send_in[o]  = noc_pkg::port_e'(idx);
          send_vch[o] = in_vch[idx];
        end
      end
    end
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      deq[i] = '0;
    end
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      if (send[o]) begin
        deq[send_in[o]][send_vch[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_rr <= '0;
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        owned[o]  <= '0;
        out_rr[o] <= '0;
        for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
          owner[o][v] <= noc_pkg::PORT_LOCAL;
        end
      end
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        if (send[o]) begin
          out_rr[o] <= (send_in[o] == noc_pkg::PORT_SOUTH) ? 3'd0 : 3'(send_in[o]) + 3'd1;
          in_rr[send_in[o]] <= ~send_vch[o];
          // Single flits never take ownership
          if (req_kind[send_in[o]][send_vch[o]] == noc_pkg::FLIT_HEAD) begin
            owned[o][send_vch[o]] <= 1'b1;
            owner[o][send_vch[o]] <= send_in[o];
          end else if (req_kind[send_in[o]][send_vch[o]] == noc_pkg::FLIT_TAIL) begin
            owned[o][send_vch[o]] <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== hw/input_vc_buffer.sv ====
`timescale 1ns/1ps

module input_vc_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [1:0]                 my_xpos,
  input  logic [1:0]                 my_ypos,
  input  noc_pkg::link_in_t          in_link,
  output noc_pkg::link_ctl_t         in_ctl,
  input  logic [noc_pkg::NUM_VC-1:0] deq,
  output noc_pkg::flit_t             head_flit [noc_pkg::NUM_VC],
  output logic [noc_pkg::NUM_VC-1:0] req_valid,
  output noc_pkg::port_e             req_port  [noc_pkg::NUM_VC]
);

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  noc_pkg::flit_t             mem     [noc_pkg::NUM_VC][BUF_DEPTH];
  logic [PTR_W-1:0]           wr_ptr  [noc_pkg::NUM_VC];
  logic [PTR_W-1:0]           rd_ptr  [noc_pkg::NUM_VC];
  logic [CNT_W-1:0]           count   [noc_pkg::NUM_VC];
  noc_pkg::port_e             route_q [noc_pkg::NUM_VC];
  logic [noc_pkg::NUM_VC-1:0] enq;
  logic [noc_pkg::NUM_VC-1:0] rdy;
  logic [noc_pkg::NUM_VC-1:0] ack_q;
  logic [noc_pkg::NUM_VC-1:0] lck_q;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Dimension order, X first, then Y, local once both match
  function automatic noc_pkg::port_e xy_route(input logic [1:0] dst_x, input logic [1:0] dst_y,
                                              input logic [1:0] cur_x, input logic [1:0] cur_y);
    if (dst_x > cur_x) return noc_pkg::PORT_EAST;
    if (dst_x < cur_x) return noc_pkg::PORT_WEST;
    if (dst_y > cur_y) return noc_pkg::PORT_NORTH;
    if (dst_y < cur_y) return noc_pkg::PORT_SOUTH;
    return noc_pkg::PORT_LOCAL;
  endfunction

  always_comb begin
    noc_pkg::head_payload_t hdr;
    for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
      enq[v]       = in_link.valid && (in_link.vch == 1'(v));
      head_flit[v] = mem[v][rd_ptr[v]];
      req_valid[v] = (count[v] != '0);
      rdy[v]       = (count[v] <= CNT_W'(BUF_DEPTH - 2));
      hdr          = head_flit[v].payload;
      // Body and tail follow the route their head took
      if (head_flit[v].kind inside {noc_pkg::FLIT_HEAD, noc_pkg::FLIT_SINGLE}) begin
        req_port[v] = xy_route(hdr.dst_x, hdr.dst_y, my_xpos, my_ypos);
      end else begin
        req_port[v] = route_q[v];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
      if (enq[v]) begin
        mem[v][wr_ptr[v]] <= in_link.flit;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        wr_ptr[v]  <= '0;
        rd_ptr[v]  <= '0;
        count[v]   <= '0;
        route_q[v] <= noc_pkg::PORT_LOCAL;
      end
      ack_q <= '0;
      lck_q <= '0;
    end else begin
      // Credit return, one pulse per dequeued flit
      ack_q <= deq;
      for (int v = 0; v < noc_pkg::NUM_VC; v++) begin
        if (enq[v]) begin
          wr_ptr[v] <= ptr_next(wr_ptr[v]);
        end
        if (deq[v]) begin
          rd_ptr[v] <= ptr_next(rd_ptr[v]);
          if (head_flit[v].kind == noc_pkg::FLIT_HEAD) begin
            route_q[v] <= req_port[v];
          end
        end
        case ({enq[v], deq[v]})
          2'b10:   count[v] <= count[v] + 1'b1;
          2'b01:   count[v] <= count[v] - 1'b1;
          default: count[v] <= count[v];
        endcase
        // Channel is mid-packet from accepted head to accepted tail
        if (enq[v] && in_link.flit.kind == noc_pkg::FLIT_HEAD) begin
          lck_q[v] <= 1'b1;
        end else if (enq[v] && in_link.flit.kind == noc_pkg::FLIT_TAIL) begin
          lck_q[v] <= 1'b0;
        end
      end
    end
  end

  assign in_ctl = '{ack: ack_q, rdy: rdy, lck: lck_q};

endmodule

// ==== hw/noc_pkg.sv ====
package noc_pkg;

  // Router structure, fixed by the mesh topology
  localparam int NUM_PORTS = 5;
  localparam int NUM_VC    = 2;

  // Single is a one-flit packet, head and tail at once
  typedef enum logic [1:0] {
    FLIT_HEAD   = 2'd0,
    FLIT_BODY   = 2'd1,
    FLIT_TAIL   = 2'd2,
    FLIT_SINGLE = 2'd3
  } flit_type_e;

  typedef struct packed {
    flit_type_e  kind;
    logic [32:0] payload;
  } flit_t;

  // Payload layout of a head or single flit
  typedef struct packed {
    logic [1:0]  dst_x;
    logic [1:0]  dst_y;
    logic [28:0] data;
  } head_payload_t;

  // East is +x, west is -x, north is +y, south is -y
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,
    PORT_EAST  = 3'd1,
    PORT_WEST  = 3'd2,
    PORT_NORTH = 3'd3,
    PORT_SOUTH = 3'd4
  } port_e;

  // One direction of flit traffic
  typedef struct packed {
    flit_t flit;
    logic  valid;
    logic  vch;
  } link_in_t;

  // Per-channel flow control returned against a link
  typedef struct packed {
    logic [NUM_VC-1:0] ack;
    logic [NUM_VC-1:0] rdy;
    logic [NUM_VC-1:0] lck;
  } link_ctl_t;

endpackage
